//--- vlog.f
+incdir+design
design/lcd_pkg.sv
design/lcd_page_sequencer.sv
design/lcd_op_expander.sv
design/lcd_nibble_strobe.sv
design/lcd_display.sv
bench/lcd_display_tb.sv

//--- Bender.yml
package:
  name: lcd_display

sources:
  - include_dirs:
      - design
    files:
      - design/lcd_pkg.sv
      - design/lcd_page_sequencer.sv
      - design/lcd_op_expander.sv
      - design/lcd_nibble_strobe.sv
      - design/lcd_display.sv

  - target: test
    include_dirs:
      - design
    files:
      - bench/lcd_display_tb.sv

//--- bench/lcd_display_tb.sv
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_display_tb;

	localparam int timeout_cycles = 2_000_000;
	localparam int quiet_cycles = 20_000;  // longer than any settle after a char
	localparam int n_bytes = 3 + 2 * `LCD_CHARS_PER_LINE;  // clear, 2 addresses, chars
	localparam int page_strobes = 10 + 2 * n_bytes;

	logic                     CCLK;
	logic                     lcdreset;
	logic [`LCD_STR_BITS-1:0] strdata;
	logic                     rslcd;
	logic                     rwlcd;
	logic                     elcd;
	logic [`LCD_NIB_BITS-1:0] lcdd;

	logic [4:0]               strobes[$];  // {rslcd, lcdd} per elcd fall
	logic [3:0]               init_nib[10] = '{4'h3, 4'h3, 4'h3, 4'h2, 4'h2,
	                                           4'h8, 4'h0, 4'h6, 4'h0, 4'hc};
	logic [8:0]               exp_bytes[n_bytes];  // {rs, byte}
	logic                     elcd_d;
	logic [`LCD_NIB_BITS-1:0] lcdd_rise;
	logic                     timed_out;
	int                       high_cnt;
	int                       mon_errs;
	int                       errors;
	int                       tests_run;
	int                       tests_failed;

	lcd_display uut (
		.CCLK(CCLK), .lcdreset(lcdreset), .strdata(strdata),
		.rslcd(rslcd), .rwlcd(rwlcd), .elcd(elcd), .lcdd(lcdd)
	);

	always #5 CCLK = ~CCLK;

	// bus monitor sampling the values from before each edge
	always @(posedge CCLK) begin
		assert (rwlcd === 1'b0)
			else begin
				$display("ERROR: rwlcd = %h, expected 0", rwlcd);
				mon_errs++;
			end
		if (elcd === 1'b1) begin
			if (elcd_d !== 1'b1)
				lcdd_rise = lcdd;  // first high cycle
			high_cnt++;
			assert (lcdd === lcdd_rise)
				else begin
					$display("ERROR: lcdd = %h while elcd high, expected %h",
						lcdd, lcdd_rise);
					mon_errs++;
				end
		end else if (elcd_d === 1'b1) begin
			assert (high_cnt == `LCD_E_HIGH)
				else begin
					$display("ERROR: elcd high cycles = %h, expected %h", high_cnt, `LCD_E_HIGH);
					mon_errs++;
				end
			strobes.push_back({rslcd, lcdd});
			high_cnt = 0;
		end
		elcd_d = elcd;
	end

	function automatic logic [`LCD_STR_BITS-1:0] random_string();
		logic [`LCD_STR_BITS-1:0] s;
		for (int i = 0; i < `LCD_STR_BITS / 8; i++)
			s[8*i +: 8] = 8'h20 + 8'($urandom % 95);  // printable ascii
		return s;
	endfunction

	// expected command and data bytes after the init nibbles
	function automatic void build_expected(input logic [`LCD_STR_BITS-1:0] s);
		exp_bytes[0] = {1'b0, 8'h01};
		exp_bytes[1] = {1'b0, 8'h80};
		for (int i = 0; i < `LCD_CHARS_PER_LINE; i++) begin
			exp_bytes[2 + i] = {1'b1, s[`LCD_STR_BITS - 1 - 8*i -: 8]};
			exp_bytes[3 + `LCD_CHARS_PER_LINE + i] =
				{1'b1, s[`LCD_STR_BITS - 1 - 8*(`LCD_CHARS_PER_LINE + i) -: 8]};
		end
		exp_bytes[2 + `LCD_CHARS_PER_LINE] = {1'b0, 8'hc0};
	endfunction

	task automatic wait_strobes(input int n);
		int t;
		t = 0;
		@(negedge CCLK);
		while (!timed_out && strobes.size() < n && t < timeout_cycles) begin
			@(negedge CCLK);
			t++;
		end
		if (!timed_out && strobes.size() < n) begin
			$display("timeout: only %0d of %0d strobes seen on elcd", strobes.size(), n);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic check_init(input int base);
		for (int i = 0; i < 10; i++)
			assert (strobes[base + i] === {1'b0, init_nib[i]})
				else begin
					$display("ERROR: init strobe %0d {rslcd,lcdd} = %h, expected %h",
						i, strobes[base + i], {1'b0, init_nib[i]});
					errors++;
				end
	endtask

	task automatic check_bytes(input int base, input int first, input int last);
		logic [4:0] hi;
		logic [4:0] lo;
		for (int j = first; j <= last; j++) begin
			hi = strobes[base + 10 + 2*j];
			lo = strobes[base + 11 + 2*j];
			assert (lo[4] === hi[4])
				else begin
					$display("ERROR: rslcd of byte %0d low nibble = %h, expected %h",
						j, lo[4], hi[4]);
					errors++;
				end
			assert ({hi[4], hi[3:0], lo[3:0]} === exp_bytes[j])
				else begin
					$display("ERROR: byte %0d {rslcd,lcdd,lcdd} = %h, expected %h",
						j, {hi[4], hi[3:0], lo[3:0]}, exp_bytes[j]);
					errors++;
				end
		end
	endtask

	task automatic report(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic test_init_nibbles();
		int e0;
		e0 = errors;
		lcdreset <= 1'b1;
		repeat (2) @(posedge CCLK);
		lcdreset <= 1'b0;
		wait_strobes(10);
		if (!timed_out)
			check_init(0);
		report("init_nibbles", e0);
	endtask

	task automatic test_command_bytes();
		int e0;
		e0 = errors;
		wait_strobes(14);
		if (!timed_out)
			check_bytes(0, 0, 1);
		report("command_bytes", e0);
	endtask

	task automatic test_string_write();
		int e0;
		e0 = errors;
		wait_strobes(page_strobes);
		if (!timed_out)
			check_bytes(0, 2, n_bytes - 1);
		report("string_write", e0);
	endtask

	task automatic test_pulse_timing();
		int e0;
		e0 = errors;
		assert (mon_errs == 0)
			else begin
				$display("monitor found %0d bad elcd pulses or rwlcd values", mon_errs);
				errors++;
			end
		report("pulse_timing", e0);
	endtask

	task automatic test_restart();
		int e0;
		int m0;
		int base;
		int t;
		logic [`LCD_STR_BITS-1:0] s2;
		logic [`LCD_STR_BITS-1:0] s3;
		e0 = errors;
		m0 = mon_errs;
		s2 = random_string();
		s3 = random_string();
		base = strobes.size();
		@(posedge CCLK);
		strdata <= s2;
		wait_strobes(base + 10 + 2 * 7);  // five chars into line 1
		if (!timed_out) begin
			base = strobes.size();
			@(posedge CCLK);
			strdata <= s3;                // elcd is in its hold phase here
			build_expected(s3);
			wait_strobes(base + page_strobes);
		end
		if (!timed_out) begin
			check_init(base);
			check_bytes(base, 0, n_bytes - 1);
			t = 0;
			while (strobes.size() == base + page_strobes && t < quiet_cycles) begin
				@(negedge CCLK);
				t++;
			end
			assert (strobes.size() == base + page_strobes)
				else begin
					$display("%0d extra strobes after the page ended",
						strobes.size() - base - page_strobes);
					errors++;
				end
		end
		assert (mon_errs == m0)
			else begin
				$display("monitor found bad elcd pulses or rwlcd values after the restart");
				errors++;
			end
		report("restart", e0);
	endtask

	initial begin
		CCLK = 1'b0;
		lcdreset = 1'b1;
		elcd_d = 1'b0;
		timed_out = 1'b0;
		high_cnt = 0;
		mon_errs = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'hd898));
		strdata = random_string();
		build_expected(strdata);
		test_init_nibbles();
		if (!timed_out)
			test_command_bytes();
		if (!timed_out)
			test_string_write();
		test_pulse_timing();
		if (!timed_out)
			test_restart();
		$display("tests %0d, failed %0d, errors %0d",
			tests_run, tests_failed, errors + mon_errs);
		if (!timed_out && tests_failed == 0 && errors == 0 && mon_errs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- design/lcd_display.sv
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_display (
	input  logic                     CCLK,
	input  logic                     lcdreset,
	input  logic [`LCD_STR_BITS-1:0] strdata,
	output logic                     rslcd,
	output logic                     rwlcd,
	output logic                     elcd,
	output logic [`LCD_NIB_BITS-1:0] lcdd
);
	import lcd_pkg::*;

	logic                     flush;
	logic                     op_valid;
	logic                     op_ready;
	lcd_op_e                  op_kind;
	logic [7:0]               op_byte;
	logic                     nib_valid;
	logic                     nib_ready;
	logic [`LCD_NIB_BITS-1:0] nib_data;
	logic                     nib_rs;
	lcd_wait_e                nib_wait;

	assign rwlcd = 1'b0;  // write only, busy flag never read

	lcd_page_sequencer u_seq (
		.CCLK(CCLK), .lcdreset(lcdreset), .strdata(strdata), .flush(flush),
		.op_valid(op_valid), .op_kind(op_kind), .op_byte(op_byte), .op_ready(op_ready)
	);

	lcd_op_expander u_exp (
		.CCLK(CCLK), .lcdreset(lcdreset), .flush(flush),
		.op_valid(op_valid), .op_kind(op_kind), .op_byte(op_byte), .op_ready(op_ready),
		.nib_valid(nib_valid), .nib_data(nib_data), .nib_rs(nib_rs),
		.nib_wait(nib_wait), .nib_ready(nib_ready)
	);

	lcd_nibble_strobe u_strobe (
		.CCLK(CCLK), .lcdreset(lcdreset), .flush(flush),
		.nib_valid(nib_valid), .nib_data(nib_data), .nib_rs(nib_rs),
		.nib_wait(nib_wait), .nib_ready(nib_ready),
		.rslcd(rslcd), .elcd(elcd), .lcdd(lcdd)
	);

endmodule

//--- design/lcd_nibble_strobe.sv
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_nibble_strobe (
	input  logic                     CCLK,
	input  logic                     lcdreset,
	input  logic                     flush,
	input  logic                     nib_valid,
	input  logic [`LCD_NIB_BITS-1:0] nib_data,
	input  logic                     nib_rs,
	input  lcd_pkg::lcd_wait_e       nib_wait,
	output logic                     nib_ready,
	output logic                     rslcd,
	output logic                     elcd,
	output logic [`LCD_NIB_BITS-1:0] lcdd
);
	import lcd_pkg::*;

	localparam logic [`LCD_CNT_BITS-1:0] setup_last = `LCD_CNT_BITS'(`LCD_E_SETUP - 1);
	localparam logic [`LCD_CNT_BITS-1:0] high_last = `LCD_CNT_BITS'(`LCD_E_HIGH - 1);
	localparam logic [`LCD_CNT_BITS-1:0] hold_last = `LCD_CNT_BITS'(`LCD_E_HOLD - 1);

	typedef enum logic [2:0] {ph_idle, ph_setup, ph_high, ph_hold, ph_settle} phase_e;

	phase_e                  phase;
	logic [`LCD_CNT_BITS-1:0] cnt;
	logic [`LCD_CNT_BITS-1:0] settle_last;  // latched at accept
	logic [`LCD_CNT_BITS-1:0] wait_last;

	always_comb begin
		case (nib_wait)
			wait_cmd: wait_last = `LCD_CNT_BITS'(`LCD_WAIT_CMD - 1);
			wait_8k: wait_last = `LCD_CNT_BITS'(`LCD_WAIT_8K - 1);
			wait_long: wait_last = `LCD_CNT_BITS'(`LCD_WAIT_LONG - 1);
			wait_power: wait_last = `LCD_CNT_BITS'(`LCD_WAIT_POWER - 1);
			default: wait_last = `LCD_CNT_BITS'(`LCD_WAIT_SHORT - 1);
		endcase
	end

	always_ff @(posedge CCLK) begin
		if (lcdreset) begin
			phase <= ph_idle;
			cnt <= '0;
			nib_ready <= 1'b1;
			elcd <= 1'b0;
			rslcd <= 1'b0;
			lcdd <= '0;
		end else if (flush) begin
			phase <= ph_idle;   // abandon the strobe, pins keep their value
			cnt <= '0;
			nib_ready <= 1'b1;
			elcd <= 1'b0;
		end else begin
			case (phase)
				ph_idle: begin
					if (nib_valid && nib_ready) begin
						lcdd <= nib_data;
						rslcd <= nib_rs;
						settle_last <= wait_last;
						nib_ready <= 1'b0;
						cnt <= '0;
						phase <= ph_setup;
					end
				end
				ph_setup: begin
					if (cnt == setup_last) begin
						elcd <= 1'b1;
						cnt <= '0;
						phase <= ph_high;
					end else
						cnt <= cnt + 1'b1;
				end
				ph_high: begin
					if (cnt == high_last) begin
						elcd <= 1'b0;   // lcd latches on this edge
						cnt <= '0;
						phase <= ph_hold;
					end else
						cnt <= cnt + 1'b1;
				end
				ph_hold: begin
					if (cnt == hold_last) begin
						cnt <= '0;
						phase <= ph_settle;
					end else
						cnt <= cnt + 1'b1;
				end
				ph_settle: begin
					if (cnt == settle_last) begin
						cnt <= '0;
						nib_ready <= 1'b1;
						phase <= ph_idle;
					end else
						cnt <= cnt + 1'b1;
				end
				default: phase <= ph_idle;
			endcase
		end
	end

endmodule

//--- design/lcd_op_expander.sv
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_op_expander (
	input  logic                     CCLK,
	input  logic                     lcdreset,
	input  logic                     flush,
	input  logic                     op_valid,
	input  lcd_pkg::lcd_op_e         op_kind,
	input  logic [7:0]               op_byte,
	output logic                     op_ready,
	output logic                     nib_valid,
	output logic [`LCD_NIB_BITS-1:0] nib_data,
	output logic                     nib_rs,
	output lcd_pkg::lcd_wait_e       nib_wait,
	input  logic                     nib_ready
);
	import lcd_pkg::*;

	lcd_op_e                  kind_q;
	logic [7:0]               byte_q;
	logic [3:0]               nib_idx;   // next nibble of the held op
	logic                     nib_last;  // nibble on the output ends the op
	lcd_op_e                  src_kind;
	logic [7:0]               src_byte;
	logic [3:0]               src_idx;
	logic [`LCD_NIB_BITS-1:0] nx_data;
	logic                     nx_rs;
	lcd_wait_e                nx_wait;
	logic                     nx_last;

	// while idle, decode the incoming op, otherwise the held one
	always_comb begin
		src_kind = op_ready ? op_kind : kind_q;
		src_byte = op_ready ? op_byte : byte_q;
		src_idx = op_ready ? 4'd0 : nib_idx;
	end

	always_comb begin
		nx_data = '0;
		nx_rs = 1'b0;
		nx_wait = wait_short;
		nx_last = 1'b0;
		case (src_kind)
			op_init: begin
				nx_last = (src_idx == 4'd9);
				case (src_idx)
					4'd0, 4'd1, 4'd2: nx_data = 4'h3;
					4'd3, 4'd4: nx_data = 4'h2;  // 4-bit mode, then function set
					4'd5: nx_data = 4'h8;
					4'd7: nx_data = 4'h6;        // entry mode
					4'd9: nx_data = 4'hc;        // display on
					default: nx_data = 4'h0;
				endcase
				case (src_idx)
					4'd0: nx_wait = wait_power;
					4'd1: nx_wait = wait_8k;
					4'd4, 4'd6, 4'd8: nx_wait = wait_short;
					default: nx_wait = wait_cmd;
				endcase
			end
			op_clear: begin
				nx_last = src_idx[0];
				nx_data = src_idx[0] ? 4'h1 : 4'h0;
				nx_wait = src_idx[0] ? wait_long : wait_short;
			end
			op_addr: begin
				nx_last = src_idx[0];
				nx_data = src_idx[0] ? src_byte[3:0] : {1'b1, src_byte[6:4]};
				nx_wait = src_idx[0] ? wait_cmd : wait_short;
			end
			default: begin  // op_char
				nx_last = src_idx[0];
				nx_rs = 1'b1;
				nx_data = src_idx[0] ? src_byte[3:0] : src_byte[7:4];
				nx_wait = src_idx[0] ? wait_cmd : wait_short;
			end
		endcase
	end

	always_ff @(posedge CCLK) begin
		if (lcdreset || flush) begin
			op_ready <= 1'b1;
			nib_valid <= 1'b0;
			nib_idx <= 4'd0;
			nib_last <= 1'b0;
		end else if (op_valid && op_ready) begin
			kind_q <= op_kind;
			byte_q <= op_byte;
			op_ready <= 1'b0;
			nib_valid <= 1'b1;      // first nibble straight away
			nib_data <= nx_data;
			nib_rs <= nx_rs;
			nib_wait <= nx_wait;
			nib_last <= nx_last;
			nib_idx <= 4'd1;
		end else if (nib_valid && nib_ready) begin
			if (nib_last) begin
				nib_valid <= 1'b0;
				op_ready <= 1'b1;   // op fully handed on
			end else begin
				nib_data <= nx_data;
				nib_rs <= nx_rs;
				nib_wait <= nx_wait;
				nib_last <= nx_last;
				nib_idx <= nib_idx + 4'd1;
			end
		end
	end

endmodule

//--- design/lcd_page_sequencer.sv
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_page_sequencer (
	input  logic                     CCLK,
	input  logic                     lcdreset,
	input  logic [`LCD_STR_BITS-1:0] strdata,
	output logic                     flush,
	output logic                     op_valid,
	output lcd_pkg::lcd_op_e         op_kind,
	output logic [7:0]               op_byte,
	input  logic                     op_ready
);
	import lcd_pkg::*;

	localparam int n_chars = `LCD_STR_BITS / 8;
	localparam int idx_bits = $clog2(n_chars);

	typedef enum logic [2:0] {
		st_init,
		st_clear,
		st_addr1,
		st_chars1,
		st_addr2,
		st_chars2,
		st_done
	} step_e;

	step_e                    step;
	logic [`LCD_STR_BITS-1:0] str_q;    // string being shown
	logic [idx_bits-1:0]      char_idx; // byte index, top byte first

	always_ff @(posedge CCLK) begin
		if (lcdreset) begin
			step <= st_init;
			flush <= 1'b0;
			op_valid <= 1'b0;
			op_kind <= op_init;
			op_byte <= 8'h00;
			str_q <= strdata;    // no flush right after reset
			char_idx <= idx_bits'(n_chars - 1);
		end else if (strdata != str_q) begin
			// new string, restart the whole page
			flush <= 1'b1;
			str_q <= strdata;
			op_valid <= 1'b0;
			step <= st_init;
			char_idx <= idx_bits'(n_chars - 1);
		end else begin
			flush <= 1'b0;
			if (!op_valid || op_ready) begin  // slot free or being taken
				case (step)
					st_init: begin
						op_valid <= 1'b1;
						op_kind <= op_init;
						op_byte <= 8'h00;
						char_idx <= idx_bits'(n_chars - 1);
						step <= st_clear;
					end
					st_clear: begin
						op_kind <= op_clear;
						op_byte <= 8'h01;
						step <= st_addr1;
					end
					st_addr1: begin
						op_kind <= op_addr;
						op_byte <= 8'h80;  // line 1, column 0
						step <= st_chars1;
					end
					st_chars1: begin
						op_kind <= op_char;
						op_byte <= str_q[{char_idx, 3'b000} +: 8];
						char_idx <= char_idx - 1'b1;
						if (char_idx == idx_bits'(`LCD_CHARS_PER_LINE))
							step <= st_addr2;
					end
					st_addr2: begin
						op_kind <= op_addr;
						op_byte <= 8'hc0;  // line 2, column 0
						step <= st_chars2;
					end
					st_chars2: begin
						op_kind <= op_char;
						op_byte <= str_q[{char_idx, 3'b000} +: 8];
						char_idx <= char_idx - 1'b1;
						if (char_idx == '0)
							step <= st_done;
					end
					default: begin
						op_valid <= 1'b0;  // page complete
					end
				endcase
			end
		end
	end

endmodule

//--- design/lcd_pkg.sv
`include "lcd_settings.svh"

package lcd_pkg;

	// display operations handed from sequencer to expander
	typedef enum logic [1:0] {
		op_init,   // power-on nibble list
		op_clear,
		op_addr,   // ddram address, bit 7 set
		op_char    // data write
	} lcd_op_e;

	// settle class that follows a nibble strobe
	typedef enum logic [2:0] {
		wait_short,
		wait_cmd,
		wait_8k,
		wait_long,
		wait_power
	} lcd_wait_e;

endpackage

//--- design/lcd_settings.svh
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// bus widths
`define LCD_STR_BITS 256
`define LCD_CHARS_PER_LINE 16
`define LCD_NIB_BITS 4

// enable pulse timing in CCLK cycles
`define LCD_E_SETUP 16
`define LCD_E_HIGH 32
`define LCD_E_HOLD 16

// settle counts after a strobe
`define LCD_WAIT_SHORT 64      // ~1 us
`define LCD_WAIT_CMD 2048      // ~40 us
`define LCD_WAIT_8K 8192       // >100 us
`define LCD_WAIT_LONG 131072   // clear needs >1.64 ms
`define LCD_WAIT_POWER 262144  // first wait, >4.1 ms

// wide enough for the power-on wait
`define LCD_CNT_BITS 19

`endif
